// File: gpu_pkg.sv
/*
  2D graphics engine shared definitions
*/
`default_nettype none

package gpu_pkg;

  // Local bus geometry
  localparam int P_DATA_W = 32;
  localparam int P_ADDR_W = 8;

  // Pixel coordinate and colour widths
  localparam int P_X_W = 10;
  localparam int P_Y_W = 10;
  localparam int P_COLOR_W = 16;

  // Emitted-pixel counter, wraps at this width
  localparam int P_CNT_W = 20;

  // Register map, byte addresses
  localparam logic [P_ADDR_W-1:0] REG_CONTROL_ADDR = 8'h00;
  localparam logic [P_ADDR_W-1:0] REG_STATUS_ADDR = 8'h04;
  localparam logic [P_ADDR_W-1:0] REG_PXL_CNT_ADDR = 8'h08;

  // Job buffer, eight consecutive words
  // Word 0 action
  localparam logic [P_ADDR_W-1:0] REG_JOB_0_ADDR = 8'h10;
  // Word 1 shape
  localparam logic [P_ADDR_W-1:0] REG_JOB_1_ADDR = 8'h14;
  // Words 2 to 5 x0, y0, x1, y1
  localparam logic [P_ADDR_W-1:0] REG_JOB_2_ADDR = 8'h18;
  localparam logic [P_ADDR_W-1:0] REG_JOB_3_ADDR = 8'h1C;
  localparam logic [P_ADDR_W-1:0] REG_JOB_4_ADDR = 8'h20;
  localparam logic [P_ADDR_W-1:0] REG_JOB_5_ADDR = 8'h24;
  // Word 6 colour
  localparam logic [P_ADDR_W-1:0] REG_JOB_6_ADDR = 8'h28;
  // Word 7 spare, software scratch
  localparam logic [P_ADDR_W-1:0] REG_JOB_7_ADDR = 8'h2C;

  // Returned on reads of unmapped addresses
  localparam logic [P_DATA_W-1:0] RD_FILLER = 32'hdeadbabe;

  // Job actions, only DRAW starts the rasterizer
  typedef enum logic [1:0] {
    ACT_DRAW = 2'd0,
    ACT_FILL_RSVD = 2'd1,
    ACT_ALIAS_RSVD = 2'd2,
    ACT_NOP = 2'd3
  } action_t;

  // Supported shapes
  typedef enum logic [1:0] {
    SHP_POINT = 2'd0,
    SHP_HLINE = 2'd1,
    SHP_VLINE = 2'd2,
    SHP_RECT = 2'd3
  } shape_t;

  // Rasterizer FSM
  typedef enum logic {
    RS_IDLE = 1'b0,
    RS_WALK = 1'b1
  } raster_state_t;

endpackage

`default_nettype wire

// File: gpu_reg_decode.sv
/*
  Register file and job decoder
*/
`timescale 1ns/10ps
`default_nettype none

module gpu_reg_decode
  import gpu_pkg::*;
(
  input  wire logic                cr_intf,
  input  wire logic                arst_n,
  input  wire logic [P_ADDR_W-1:0] lb_addr,
  input  wire logic                lb_wr_en,
  input  wire logic [P_DATA_W-1:0] lb_wr_data,
  input  wire logic                lb_rd_en,
  input  wire logic                busy,
  input  wire logic [P_CNT_W-1:0]  pxl_cnt,
  output logic                     lb_wr_valid,
  output logic                     lb_rd_valid,
  output logic [P_DATA_W-1:0]      lb_rd_data,
  output logic                     job_start,
  output action_t                  cur_action,
  output shape_t                   job_shape,
  output logic [P_X_W-1:0]         job_xmin,
  output logic [P_Y_W-1:0]         job_ymin,
  output logic [P_X_W-1:0]         job_xmax,
  output logic [P_Y_W-1:0]         job_ymax,
  output logic [P_COLOR_W-1:0]     job_color
);

  // Control and job buffer contents
  logic                 ctrl_en;
  action_t              job_action;
  shape_t               job_shape_q;
  logic [P_X_W-1:0]     job_x0;
  logic [P_Y_W-1:0]     job_y0;
  logic [P_X_W-1:0]     job_x1;
  logic [P_Y_W-1:0]     job_y1;
  logic [P_COLOR_W-1:0] job_color_q;
  logic [P_DATA_W-1:0]  job_spare;

  // Start request from a DRAW write to job word 0
  logic start_req;

  // Engine must be enabled and idle, and no start may already be pending
  assign start_req = lb_wr_en && (lb_addr == REG_JOB_0_ADDR)
                  && (lb_wr_data[1:0] == ACT_DRAW) && ctrl_en
                  && !busy && !job_start;

  // Bus writes, strobes and start pulse
  always_ff @(posedge cr_intf or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ctrl_en <= 1'b0;
      job_action <= ACT_DRAW;
      job_shape_q <= SHP_POINT;
      job_x0 <= '0;
      job_y0 <= '0;
      job_x1 <= '0;
      job_y1 <= '0;
      job_color_q <= '0;
      job_spare <= '0;
      lb_wr_valid <= 1'b0;
      lb_rd_valid <= 1'b0;
      job_start <= 1'b0;
    end
    else
    begin
      if (lb_wr_en)
      begin
        case (lb_addr)
          REG_CONTROL_ADDR: ctrl_en <= lb_wr_data[0];
          REG_JOB_0_ADDR:   job_action <= action_t'(lb_wr_data[1:0]);
          REG_JOB_1_ADDR:   job_shape_q <= shape_t'(lb_wr_data[1:0]);
          REG_JOB_2_ADDR:   job_x0 <= lb_wr_data[P_X_W-1:0];
          REG_JOB_3_ADDR:   job_y0 <= lb_wr_data[P_Y_W-1:0];
          REG_JOB_4_ADDR:   job_x1 <= lb_wr_data[P_X_W-1:0];
          REG_JOB_5_ADDR:   job_y1 <= lb_wr_data[P_Y_W-1:0];
          REG_JOB_6_ADDR:   job_color_q <= lb_wr_data[P_COLOR_W-1:0];
          REG_JOB_7_ADDR:   job_spare <= lb_wr_data;
          default:          ;
        endcase
      end
      // One-cycle acknowledges
      lb_wr_valid <= lb_wr_en;
      lb_rd_valid <= lb_rd_en;
      job_start <= start_req;
    end
  end

  // Read mux, fields zero-extended
  always_ff @(posedge cr_intf)
  begin
    if (lb_rd_en)
    begin
      case (lb_addr)
        REG_CONTROL_ADDR: lb_rd_data <= {{(P_DATA_W-1){1'b0}}, ctrl_en};
        REG_STATUS_ADDR:  lb_rd_data <= {{(P_DATA_W-1){1'b0}}, busy};
        REG_PXL_CNT_ADDR: lb_rd_data <= {{(P_DATA_W-P_CNT_W){1'b0}}, pxl_cnt};
        REG_JOB_0_ADDR:   lb_rd_data <= {{(P_DATA_W-2){1'b0}}, job_action};
        REG_JOB_1_ADDR:   lb_rd_data <= {{(P_DATA_W-2){1'b0}}, job_shape_q};
        REG_JOB_2_ADDR:   lb_rd_data <= {{(P_DATA_W-P_X_W){1'b0}}, job_x0};
        REG_JOB_3_ADDR:   lb_rd_data <= {{(P_DATA_W-P_Y_W){1'b0}}, job_y0};
        REG_JOB_4_ADDR:   lb_rd_data <= {{(P_DATA_W-P_X_W){1'b0}}, job_x1};
        REG_JOB_5_ADDR:   lb_rd_data <= {{(P_DATA_W-P_Y_W){1'b0}}, job_y1};
        REG_JOB_6_ADDR:   lb_rd_data <= {{(P_DATA_W-P_COLOR_W){1'b0}}, job_color_q};
        REG_JOB_7_ADDR:   lb_rd_data <= job_spare;
        default:          lb_rd_data <= RD_FILLER;
      endcase
    end
  end

  // Corners ordered so the walk always runs min to max
  assign job_xmin = (job_x0 <= job_x1) ? job_x0 : job_x1;
  assign job_xmax = (job_x0 <= job_x1) ? job_x1 : job_x0;
  assign job_ymin = (job_y0 <= job_y1) ? job_y0 : job_y1;
  assign job_ymax = (job_y0 <= job_y1) ? job_y1 : job_y0;

  assign job_shape = job_shape_q;
  assign job_color = job_color_q;
  assign cur_action = job_action;

  // Read data only ever answers a read strobe
  a_rd_valid_follows_en: assert property (
    @(posedge cr_intf) disable iff (!arst_n)
    lb_rd_valid |-> $past(lb_rd_en)
  );

  // Start is a single pulse
  a_start_single: assert property (
    @(posedge cr_intf) disable iff (!arst_n)
    job_start |=> !job_start
  );

endmodule

`default_nettype wire

// File: gpu_raster.sv
/*
  Shape rasterizer
*/
`timescale 1ns/10ps
`default_nettype none

module gpu_raster
  import gpu_pkg::*;
(
  input  wire logic                 cr_intf,
  input  wire logic                 arst_n,
  input  wire logic                 job_start,
  input  wire shape_t               job_shape,
  input  wire logic [P_X_W-1:0]     job_xmin,
  input  wire logic [P_Y_W-1:0]     job_ymin,
  input  wire logic [P_X_W-1:0]     job_xmax,
  input  wire logic [P_Y_W-1:0]     job_ymax,
  input  wire logic [P_COLOR_W-1:0] job_color,
  input  wire logic                 rast_ready,
  output logic                      busy,
  output logic                      rast_valid,
  output logic [P_X_W-1:0]          rast_x,
  output logic [P_Y_W-1:0]          rast_y,
  output logic [P_COLOR_W-1:0]      rast_color
);

  raster_state_t state;

  // Walk window latched at job start
  logic [P_X_W-1:0] row_x;
  logic [P_X_W-1:0] end_x;
  logic [P_Y_W-1:0] end_y;

  // Current position and colour
  logic [P_X_W-1:0]     cur_x;
  logic [P_Y_W-1:0]     cur_y;
  logic [P_COLOR_W-1:0] color_q;

  // Window end points derived from the shape
  logic [P_X_W-1:0] end_x_d;
  logic [P_Y_W-1:0] end_y_d;

  logic accept;
  logic row_end;
  logic last_pix;
  logic launch;

  // Lines and points collapse the box to one row or column
  always_comb
  begin
    case (job_shape)
      SHP_HLINE:
      begin
        end_x_d = job_xmax;
        end_y_d = job_ymin;
      end
      SHP_VLINE:
      begin
        end_x_d = job_xmin;
        end_y_d = job_ymax;
      end
      SHP_RECT:
      begin
        end_x_d = job_xmax;
        end_y_d = job_ymax;
      end
      default:
      begin
        end_x_d = job_xmin;
        end_y_d = job_ymin;
      end
    endcase
  end

  assign launch = (state == RS_IDLE) && job_start;
  assign accept = rast_valid && rast_ready;
  assign row_end = (cur_x == end_x);
  assign last_pix = row_end && (cur_y == end_y);

  // FSM, leaves walk the cycle after the last accepted pixel
  always_ff @(posedge cr_intf or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= RS_IDLE;
    end
    else
    begin
      case (state)
        RS_IDLE:
        begin
          if (job_start)
          begin
            state <= RS_WALK;
          end
        end
        RS_WALK:
        begin
          if (accept && last_pix)
          begin
            state <= RS_IDLE;
          end
        end
        default: state <= RS_IDLE;
      endcase
    end
  end

  // Position advances only on accepted pixels, x fastest
  always_ff @(posedge cr_intf)
  begin
    if (launch)
    begin
      row_x <= job_xmin;
      end_x <= end_x_d;
      end_y <= end_y_d;
      cur_x <= job_xmin;
      cur_y <= job_ymin;
      color_q <= job_color;
    end
    else if (accept && !last_pix)
    begin
      if (row_end)
      begin
        cur_x <= row_x;
        cur_y <= cur_y + 1'b1;
      end
      else
      begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

  // A pixel is on offer for the whole walk
  assign busy = (state == RS_WALK);
  assign rast_valid = (state == RS_WALK);
  assign rast_x = cur_x;
  assign rast_y = cur_y;
  assign rast_color = color_q;

  // Decoder must hold off starts during a walk
  a_no_start_busy: assert property (
    @(posedge cr_intf) disable iff (!arst_n)
    job_start |-> !busy
  );

  // Position frozen under back-pressure
  a_stall_stable: assert property (
    @(posedge cr_intf) disable iff (!arst_n)
    (rast_valid && !rast_ready) |=> ($stable(rast_x) && $stable(rast_y))
  );

endmodule

`default_nettype wire

// File: gpu_pxl_out.sv
/*
  Pixel output stage
*/
`timescale 1ns/10ps
`default_nettype none

module gpu_pxl_out
  import gpu_pkg::*;
(
  input  wire logic                 cr_intf,
  input  wire logic                 arst_n,
  input  wire action_t              cur_action,
  input  wire logic                 rast_valid,
  input  wire logic [P_X_W-1:0]     rast_x,
  input  wire logic [P_Y_W-1:0]     rast_y,
  input  wire logic [P_COLOR_W-1:0] rast_color,
  input  wire logic                 pxl_ready,
  output logic                      rast_ready,
  output logic                      pxl_valid,
  output logic [P_X_W-1:0]          pxl_x,
  output logic [P_Y_W-1:0]          pxl_y,
  output logic [P_COLOR_W-1:0]      pxl_color,
  output logic [P_CNT_W-1:0]        pxl_cnt
);

  logic draw_sel;
  logic full_q;
  // Set while the rasterizer has not yet handed over a pixel of the job
  logic idle_seen;
  logic take;
  logic give;

  // Only the draw engine drives the port
  assign draw_sel = (cur_action == ACT_DRAW);
  assign pxl_valid = full_q && draw_sel;
  // Empty, or being emptied this cycle
  assign rast_ready = draw_sel && (!full_q || pxl_ready);
  assign take = rast_valid && rast_ready;
  assign give = pxl_valid && pxl_ready;

  always_ff @(posedge cr_intf or negedge arst_n)
  begin
    if (!arst_n)
    begin
      full_q <= 1'b0;
      idle_seen <= 1'b1;
      pxl_cnt <= '0;
    end
    else
    begin
      if (take)
        full_q <= 1'b1;
      else if (give)
        full_q <= 1'b0;
      // Rasterizer goes quiet between jobs
      if (!rast_valid)
        idle_seen <= 1'b1;
      else if (take)
        idle_seen <= 1'b0;
      // First pixel of a job restarts the count
      if (take && idle_seen)
        pxl_cnt <= '0;
      else if (give)
        pxl_cnt <= pxl_cnt + 1'b1;
    end
  end

  // Holding register data
  always_ff @(posedge cr_intf)
  begin
    if (take)
    begin
      pxl_x <= rast_x;
      pxl_y <= rast_y;
      pxl_color <= rast_color;
    end
  end

  // Offered pixel holds until taken, unless the action leaves DRAW
  a_pxl_hold: assert property (
    @(posedge cr_intf) disable iff (!arst_n)
    (pxl_valid && !pxl_ready) |=> (cur_action != ACT_DRAW)
      || (pxl_valid && $stable(pxl_x) && $stable(pxl_y) && $stable(pxl_color))
  );

endmodule

`default_nettype wire

// File: gpu_core.sv
/*
  Graphics engine core
*/
`timescale 1ns/10ps
`default_nettype none

module gpu_core
  import gpu_pkg::*;
(
  input  wire logic                cr_intf,
  input  wire logic                arst_n,
  input  wire logic [P_ADDR_W-1:0] lb_addr,
  input  wire logic                lb_wr_en,
  input  wire logic [P_DATA_W-1:0] lb_wr_data,
  input  wire logic                lb_rd_en,
  input  wire logic                pxl_ready,
  output logic                     lb_wr_valid,
  output logic                     lb_rd_valid,
  output logic [P_DATA_W-1:0]      lb_rd_data,
  output logic                     pxl_valid,
  output logic [P_X_W-1:0]         pxl_x,
  output logic [P_Y_W-1:0]         pxl_y,
  output logic [P_COLOR_W-1:0]     pxl_color
);

  // Decoder to rasterizer
  logic                 job_start;
  shape_t               job_shape;
  logic [P_X_W-1:0]     job_xmin;
  logic [P_Y_W-1:0]     job_ymin;
  logic [P_X_W-1:0]     job_xmax;
  logic [P_Y_W-1:0]     job_ymax;
  logic [P_COLOR_W-1:0] job_color;
  logic                 busy;

  // Rasterizer to output stage
  logic                 rast_valid;
  logic                 rast_ready;
  logic [P_X_W-1:0]     rast_x;
  logic [P_Y_W-1:0]     rast_y;
  logic [P_COLOR_W-1:0] rast_color;

  // Output stage back to decoder
  action_t              cur_action;
  logic [P_CNT_W-1:0]   pxl_cnt;

  gpu_reg_decode u_reg_decode (
    .cr_intf(cr_intf), .arst_n(arst_n),
    .lb_addr(lb_addr), .lb_wr_en(lb_wr_en), .lb_wr_data(lb_wr_data),
    .lb_rd_en(lb_rd_en), .busy(busy), .pxl_cnt(pxl_cnt),
    .lb_wr_valid(lb_wr_valid), .lb_rd_valid(lb_rd_valid), .lb_rd_data(lb_rd_data),
    .job_start(job_start), .cur_action(cur_action), .job_shape(job_shape),
    .job_xmin(job_xmin), .job_ymin(job_ymin), .job_xmax(job_xmax),
    .job_ymax(job_ymax), .job_color(job_color)
  );

  gpu_raster u_raster (
    .cr_intf(cr_intf), .arst_n(arst_n),
    .job_start(job_start), .job_shape(job_shape),
    .job_xmin(job_xmin), .job_ymin(job_ymin), .job_xmax(job_xmax),
    .job_ymax(job_ymax), .job_color(job_color), .rast_ready(rast_ready),
    .busy(busy), .rast_valid(rast_valid),
    .rast_x(rast_x), .rast_y(rast_y), .rast_color(rast_color)
  );

  gpu_pxl_out u_pxl_out (
    .cr_intf(cr_intf), .arst_n(arst_n), .cur_action(cur_action),
    .rast_valid(rast_valid), .rast_x(rast_x), .rast_y(rast_y),
    .rast_color(rast_color), .pxl_ready(pxl_ready), .rast_ready(rast_ready),
    .pxl_valid(pxl_valid), .pxl_x(pxl_x), .pxl_y(pxl_y),
    .pxl_color(pxl_color), .pxl_cnt(pxl_cnt)
  );

endmodule

`default_nettype wire

// File: tb_gpu_tasks.svh
/*
  Graphics engine testbench tasks
*/
`ifndef TB_GPU_TASKS_SVH
`define TB_GPU_TASKS_SVH

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Writable bits of each job word
  function automatic logic [31:0] job_mask(input int word);
    case (word)
      0, 1:    return 32'h3;
      2, 4:    return (32'd1 << P_X_W) - 32'd1;
      3, 5:    return (32'd1 << P_Y_W) - 32'd1;
      6:       return (32'd1 << P_COLOR_W) - 32'd1;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  // Entered and left on a falling edge
  task automatic lb_write(input logic [P_ADDR_W-1:0] addr, input logic [P_DATA_W-1:0] data);
    lb_addr = addr;
    lb_wr_data = data;
    lb_wr_en = 1'b1;
    @(negedge cr_intf);
    check({cur_test, " wr_valid"}, 1, lb_wr_valid);
    lb_wr_en = 1'b0;
  endtask

  task automatic lb_read(input logic [P_ADDR_W-1:0] addr, output logic [P_DATA_W-1:0] data);
    lb_addr = addr;
    lb_rd_en = 1'b1;
    @(negedge cr_intf);
    check({cur_test, " rd_valid"}, 1, lb_rd_valid);
    data = lb_rd_data;
    lb_rd_en = 1'b0;
  endtask

  // Small random box with corner 0 at the low end
  task automatic pick_box(output int x0, output int y0, output int x1, output int y1,
                          output int col);
    x0 = $urandom_range(0, 1000);
    y0 = $urandom_range(0, 1000);
    x1 = x0 + $urandom_range(0, 7);
    y1 = y0 + $urandom_range(0, 5);
    col = $urandom_range(0, 65535);
  endtask

  // Reference walk from min to max with x fastest
  task automatic build_expected(input shape_t shape, input int x0, input int y0,
                                input int x1, input int y1, input int col);
    int xa;
    int xb;
    int ya;
    int yb;
    exp_x.delete();
    exp_y.delete();
    exp_c.delete();
    xa = (x0 < x1) ? x0 : x1;
    xb = (x0 < x1) ? x1 : x0;
    ya = (y0 < y1) ? y0 : y1;
    yb = (y0 < y1) ? y1 : y0;
    if (shape == SHP_POINT || shape == SHP_VLINE)
      xb = xa;
    if (shape == SHP_POINT || shape == SHP_HLINE)
      yb = ya;
    for (int y = ya; y <= yb; y++)
    begin
      for (int x = xa; x <= xb; x++)
      begin
        exp_x.push_back(x);
        exp_y.push_back(y);
        exp_c.push_back(col);
      end
    end
  endtask

  // Gathers pixels while polling status until idle and drained
  task automatic collect_pixels(input string name, input bit rand_ready);
    int cyc;
    bit stat_busy;
    bit hold;
    bit done;
    int hx;
    int hy;
    int hc;
    got_x.delete();
    got_y.delete();
    got_c.delete();
    first_cyc = 0;
    cyc = 1;
    stat_busy = 1'b1;
    hold = 1'b0;
    done = 1'b0;
    hx = 0;
    hy = 0;
    hc = 0;
    while (!done)
    begin
      // Stalled pixel must not move
      if (hold)
      begin
        check({name, " hold valid"}, 1, pxl_valid);
        check({name, " hold x"}, hx, pxl_x);
        check({name, " hold y"}, hy, pxl_y);
        check({name, " hold color"}, hc, pxl_color);
      end
      if (lb_rd_valid)
        stat_busy = lb_rd_data[0];
      // Early status samples predate the job
      if (cyc >= 4 && !stat_busy && !pxl_valid)
        done = 1'b1;
      else
      begin
        // Ready driven now is the one the next rising edge sees
        pxl_ready = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
        if (pxl_valid && pxl_ready)
        begin
          got_x.push_back(int'(pxl_x));
          got_y.push_back(int'(pxl_y));
          got_c.push_back(int'(pxl_color));
          if (first_cyc == 0)
            first_cyc = cyc;
        end
        hold = pxl_valid && !pxl_ready;
        hx = int'(pxl_x);
        hy = int'(pxl_y);
        hc = int'(pxl_color);
        lb_addr = REG_STATUS_ADDR;
        lb_rd_en = 1'b1;
        @(negedge cr_intf);
        cyc++;
      end
    end
    lb_rd_en = 1'b0;
  endtask

  task automatic compare_pixels(input string name);
    check({name, " pixel total"}, exp_x.size(), got_x.size());
    for (int i = 0; i < exp_x.size() && i < got_x.size(); i++)
    begin
      check({name, " x"}, exp_x[i], got_x[i]);
      check({name, " y"}, exp_y[i], got_y[i]);
      check({name, " color"}, exp_c[i], got_c[i]);
    end
  endtask

  // One DRAW job from corner words to pixel count readback
  task automatic run_shape(input string name, input shape_t shape, input int x0,
                           input int y0, input int x1, input int y1, input int col,
                           input bit rand_ready, input bit check_first);
    int n;
    logic [P_DATA_W-1:0] rd;
    cur_test = name;
    build_expected(shape, x0, y0, x1, y1, col);
    n = exp_x.size();
    planned_pixels += n;
    lb_write(REG_JOB_1_ADDR, 32'(shape));
    lb_write(REG_JOB_2_ADDR, x0);
    lb_write(REG_JOB_3_ADDR, y0);
    lb_write(REG_JOB_4_ADDR, x1);
    lb_write(REG_JOB_5_ADDR, y1);
    lb_write(REG_JOB_6_ADDR, col);
    pxl_ready = !rand_ready;
    lb_write(REG_JOB_0_ADDR, 32'(ACT_DRAW));
    collect_pixels(name, rand_ready);
    // Strobe edge counts as cycle 0
    if (check_first)
      check({name, " first pixel cycle"}, 3, first_cyc);
    compare_pixels(name);
    lb_read(REG_PXL_CNT_ADDR, rd);
    check({name, " pixel count"}, n, rd);
  endtask

`endif

// File: tb_gpu_core.sv
/*
  Graphics engine core testbench
*/
`timescale 1ns/10ps
`default_nettype none

module tb_gpu_core
  import gpu_pkg::*;
();

  // DUT inputs
  logic                 cr_intf;
  logic                 arst_n;
  logic [P_ADDR_W-1:0]  lb_addr;
  logic                 lb_wr_en;
  logic [P_DATA_W-1:0]  lb_wr_data;
  logic                 lb_rd_en;
  logic                 pxl_ready;

  // DUT outputs
  logic                 lb_wr_valid;
  logic                 lb_rd_valid;
  logic [P_DATA_W-1:0]  lb_rd_data;
  logic                 pxl_valid;
  logic [P_X_W-1:0]     pxl_x;
  logic [P_Y_W-1:0]     pxl_y;
  logic [P_COLOR_W-1:0] pxl_color;

  // Bookkeeping
  int errors;
  int checks;
  int planned_pixels;
  int first_cyc;
  string cur_test;

  // Pixels seen on the port and pixels the model predicts
  int got_x[$];
  int got_y[$];
  int got_c[$];
  int exp_x[$];
  int exp_y[$];
  int exp_c[$];

  gpu_core uut (
    .cr_intf(cr_intf), .arst_n(arst_n),
    .lb_addr(lb_addr), .lb_wr_en(lb_wr_en), .lb_wr_data(lb_wr_data),
    .lb_rd_en(lb_rd_en), .pxl_ready(pxl_ready),
    .lb_wr_valid(lb_wr_valid), .lb_rd_valid(lb_rd_valid), .lb_rd_data(lb_rd_data),
    .pxl_valid(pxl_valid), .pxl_x(pxl_x), .pxl_y(pxl_y), .pxl_color(pxl_color)
  );

  // 10 ns clock
  always #5 cr_intf = ~cr_intf;

  `include "tb_gpu_tasks.svh"

  // Register map readback masked to field widths
  task automatic readback_registers();
    logic [P_DATA_W-1:0] wdata [8];
    logic [P_DATA_W-1:0] rd;
    logic [P_ADDR_W-1:0] addr;
    cur_test = "registers";
    check("registers wr_valid idle", 0, lb_wr_valid);
    for (int i = 0; i < 8; i++)
    begin
      wdata[i] = $urandom();
      addr = REG_JOB_0_ADDR + P_ADDR_W'(4 * i);
      lb_write(addr, wdata[i]);
    end
    // Write acknowledge is one cycle wide
    @(negedge cr_intf);
    check("registers wr_valid single", 0, lb_wr_valid);
    for (int i = 0; i < 8; i++)
    begin
      addr = REG_JOB_0_ADDR + P_ADDR_W'(4 * i);
      lb_read(addr, rd);
      check("registers job word", wdata[i] & job_mask(i), rd);
    end
    @(negedge cr_intf);
    check("registers rd_valid single", 0, lb_rd_valid);
    // Only bit 0 of control is kept
    lb_write(REG_CONTROL_ADDR, 32'hffff_fffe);
    lb_read(REG_CONTROL_ADDR, rd);
    check("registers control clear", 0, rd);
    lb_write(REG_CONTROL_ADDR, 32'h1);
    lb_read(REG_CONTROL_ADDR, rd);
    check("registers control set", 1, rd);
    // Holes in the map
    lb_read(8'h0C, rd);
    check("registers unmapped 0x0c", RD_FILLER, rd);
    lb_read(8'h30, rd);
    check("registers unmapped 0x30", RD_FILLER, rd);
    lb_read(8'hFC, rd);
    check("registers unmapped 0xfc", RD_FILLER, rd);
  endtask

  // All four shapes with ready held high
  task automatic draw_all_shapes();
    int x0;
    int y0;
    int x1;
    int y1;
    int col;
    cur_test = "shapes";
    lb_write(REG_CONTROL_ADDR, 32'h1);
    pick_box(x0, y0, x1, y1, col);
    run_shape("shape point", SHP_POINT, x0, y0, x1, y1, col, 1'b0, 1'b1);
    pick_box(x0, y0, x1, y1, col);
    run_shape("shape hline", SHP_HLINE, x0, y0, x1, y1, col, 1'b0, 1'b1);
    pick_box(x0, y0, x1, y1, col);
    run_shape("shape vline", SHP_VLINE, x0, y0, x1, y1, col, 1'b0, 1'b1);
    pick_box(x0, y0, x1, y1, col);
    run_shape("shape rect", SHP_RECT, x0, y0, x1, y1, col, 1'b0, 1'b1);
  endtask

  // Corner 0 beyond corner 1 on both axes
  task automatic swapped_corners();
    int x0;
    int y0;
    int x1;
    int y1;
    int col;
    pick_box(x0, y0, x1, y1, col);
    run_shape("swapped rect", SHP_RECT, x1 + 1, y1 + 1, x0, y0, col, 1'b0, 1'b0);
  endtask

  // Random ready pattern on the pixel port
  task automatic random_backpressure();
    int x0;
    int y0;
    int x1;
    int y1;
    int col;
    pick_box(x0, y0, x1, y1, col);
    run_shape("backpressure rect", SHP_RECT, x0, y0, x1, y1, col, 1'b1, 1'b0);
  endtask

  // Starts that must be refused
  task automatic refused_starts();
    logic [P_DATA_W-1:0] rd;
    cur_test = "gating";
    lb_write(REG_CONTROL_ADDR, 32'h0);
    lb_write(REG_JOB_1_ADDR, 32'(SHP_RECT));
    lb_write(REG_JOB_2_ADDR, 20);
    lb_write(REG_JOB_3_ADDR, 30);
    lb_write(REG_JOB_4_ADDR, 23);
    lb_write(REG_JOB_5_ADDR, 32);
    lb_write(REG_JOB_6_ADDR, 32'h1234);
    lb_write(REG_JOB_0_ADDR, 32'(ACT_DRAW));
    // A wrong start shows busy two cycles after the strobe
    repeat (2) @(negedge cr_intf);
    lb_read(REG_STATUS_ADDR, rd);
    check("gating disabled busy", 0, rd);
    collect_pixels("gating disabled", 1'b0);
    check("gating disabled pixels", 0, got_x.size());
    // NOP selected with the engine enabled
    lb_write(REG_CONTROL_ADDR, 32'h1);
    lb_write(REG_JOB_0_ADDR, 32'(ACT_NOP));
    repeat (2) @(negedge cr_intf);
    lb_read(REG_STATUS_ADDR, rd);
    check("gating nop busy", 0, rd);
    // Second DRAW lands while the first job walks
    build_expected(SHP_RECT, 20, 30, 23, 32, 32'h1234);
    planned_pixels += exp_x.size();
    pxl_ready = 1'b0;
    lb_write(REG_JOB_0_ADDR, 32'(ACT_DRAW));
    lb_write(REG_JOB_4_ADDR, 40);
    lb_write(REG_JOB_0_ADDR, 32'(ACT_DRAW));
    collect_pixels("gating busy", 1'b0);
    compare_pixels("gating busy");
  endtask

  initial
  begin : main
    int unsigned seed_ret;
    seed_ret = $urandom(32'hb3e6);
    errors = 0;
    checks = 0;
    planned_pixels = 0;
    cur_test = "setup";
    cr_intf = 1'b0;
    arst_n = 1'b0;
    lb_addr = '0;
    lb_wr_en = 1'b0;
    lb_wr_data = '0;
    lb_rd_en = 1'b0;
    pxl_ready = 1'b0;
    // Reset held for 4 cycles
    repeat (4) @(posedge cr_intf);
    @(negedge cr_intf);
    arst_n = 1'b1;
    @(negedge cr_intf);
    readback_registers();
    draw_all_shapes();
    swapped_corners();
    random_backpressure();
    refused_starts();
    $display("Finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // Budget grows as jobs are planned
  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < 200 * planned_pixels + 2000)
    begin
      @(posedge cr_intf);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycles);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
gpu_pkg.sv
gpu_reg_decode.sv
gpu_raster.sv
gpu_pxl_out.sv
gpu_core.sv
tb_gpu_core.sv

// File: run.sh
#!/bin/sh
# Compile and run the graphics engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_gpu_core

out=$(./obj_dir/Vtb_gpu_core 2>&1) || true
echo "$out"

# Pass only when the testbench printed the pass line
echo "$out" | grep -qx "all tests passed"
